// File: Makefile
TOP := cache_top_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cache_top.f hdl/*.sv test/*.sv
	verilator --binary --timing --assert -f cache_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Finished with errors" $(LOG); then exit 1; fi

lint:
	verilator --lint-only --timing --assert -f cache_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: cache_top.f
hdl/cache_pkg.sv
hdl/line_store.sv
hdl/way_select.sv
hdl/line_update.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/cache_top_props.sv
test/cache_top_tb.sv

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter  int SETS           = 16,
  parameter  int WORDS_PER_LINE = 4,
  localparam int INDEX_BITS     = $clog2(SETS),
  localparam int LINE_OFF_BITS  = $clog2(WORDS_PER_LINE * cache_pkg::WORD_BITS / 8),
  localparam int TAG_BITS       = cache_pkg::ADDR_BITS - INDEX_BITS - LINE_OFF_BITS
) (
  input  logic                 clk,
  input  logic                 rst_n,
  // CPU side
  input  logic                 cpu_req_enable,
  input  logic                 cpu_req_rw,
  input  cache_pkg::addr_t     cpu_req_addr,
  input  cache_pkg::word_t     cpu_req_wdata,
  output logic                 cpu_req_ready,
  output logic                 cpu_res_ready,
  output cache_pkg::word_t     cpu_res_rdata,
  // Memory request, data travels outside the controller
  output logic                 mem_req_enable,
  output logic                 mem_req_rw,
  output cache_pkg::addr_t     mem_req_addr,
  input  logic                 mem_res_ready,
  // Lookup results
  input  logic                 hit,
  input  logic                 victim_dirty,
  input  logic [TAG_BITS-1:0]  victim_tag,
  input  cache_pkg::word_t     rd_word,
  // Registered request
  output cache_pkg::addr_t     req_addr,
  output logic                 req_rw,
  output cache_pkg::word_t     req_wdata,
  // Storage and line update control
  output logic                 store_rd_en,
  output logic                 store_line_wr,
  output logic                 store_age_wr,
  output logic                 fill_load,
  output logic                 use_fill
);

  import cache_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        miss_q;  // Access missed in LOOKUP
  logic        accept;
  addr_t       wb_addr;
  addr_t       fill_addr;

  assign accept = cpu_req_enable && cpu_req_ready;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= cpu_req_addr;
      req_rw    <= cpu_req_rw;
      req_wdata <= cpu_req_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == LOOKUP) begin
        miss_q <= !hit;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_d = UPDATE;
        end else if (victim_dirty) begin
          state_d = WRITEBACK;  // Victim must reach memory first
        end else begin
          state_d = FILL;
        end
      end
      WRITEBACK: begin
        if (mem_res_ready) begin
          state_d = FILL;
        end
      end
      FILL: begin
        if (mem_res_ready) begin
          state_d = UPDATE;
        end
      end
      UPDATE: begin
        state_d = IDLE;  // Single cycle response
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // Write-back goes to the victim's own line, refill to the requested one
  assign wb_addr   = {victim_tag, req_addr[LINE_OFF_BITS +: INDEX_BITS], {LINE_OFF_BITS{1'b0}}};
  assign fill_addr = {req_addr[ADDR_BITS-1:LINE_OFF_BITS], {LINE_OFF_BITS{1'b0}}};

  assign mem_req_enable = (state_q == WRITEBACK) || (state_q == FILL);
  assign mem_req_rw     = (state_q == WRITEBACK);
  assign mem_req_addr   = mem_req_rw ? wb_addr : fill_addr;

  assign cpu_req_ready = (state_q == IDLE);
  assign cpu_res_ready = (state_q == UPDATE);
  assign cpu_res_rdata = (cpu_res_ready && !req_rw) ? rd_word : '0;

  assign store_rd_en   = accept;
  assign store_age_wr  = cpu_res_ready;
  assign store_line_wr = cpu_res_ready && (miss_q || req_rw);  // Read hit keeps the line
  assign fill_load     = (state_q == FILL) && mem_res_ready;
  assign use_fill      = miss_q;

endmodule

`default_nettype wire

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int WAYS      = 4;  // Two age bits rank exactly four ways
  localparam int AGE_BITS  = 2;
  localparam int ADDR_BITS = 32;
  localparam int WORD_BITS = 32;

  // CPU byte address
  typedef logic [ADDR_BITS-1:0] addr_t;

  typedef logic [WORD_BITS-1:0] word_t;

  // 0 is the most recent way, 3 the least recent
  typedef logic [AGE_BITS-1:0] age_t;

  typedef logic [WAYS-1:0] way_mask_t;  // One bit per way

  localparam age_t AGE_OLDEST = age_t'(WAYS - 1);

  typedef enum logic [2:0] {
    IDLE,       // Waiting for a CPU request
    LOOKUP,     // Set is available, hit check
    WRITEBACK,  // Dirty victim goes to memory
    FILL,       // Line refill from memory
    UPDATE      // Storage write and CPU response
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
  parameter  int SETS           = 16,
  parameter  int WORDS_PER_LINE = 4,
  localparam int LINE_BITS      = WORDS_PER_LINE * cache_pkg::WORD_BITS
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // CPU side
  input  logic                  cpu_req_enable,
  input  logic                  cpu_req_rw,
  input  cache_pkg::addr_t      cpu_req_addr,
  input  cache_pkg::word_t      cpu_req_wdata,
  output logic                  cpu_req_ready,
  output logic                  cpu_res_ready,
  output cache_pkg::word_t      cpu_res_rdata,
  // Memory side
  output logic                  mem_req_enable,
  output logic                  mem_req_rw,
  output cache_pkg::addr_t      mem_req_addr,
  output logic [LINE_BITS-1:0]  mem_req_wdata,
  input  logic                  mem_res_ready,
  input  logic [LINE_BITS-1:0]  mem_res_rdata
);

  import cache_pkg::*;

  localparam int INDEX_BITS    = $clog2(SETS);
  localparam int OFFSET_BITS   = $clog2(WORDS_PER_LINE);
  localparam int LINE_OFF_BITS = $clog2(LINE_BITS / 8);
  localparam int BYTE_BITS     = LINE_OFF_BITS - OFFSET_BITS;
  localparam int TAG_BITS      = ADDR_BITS - INDEX_BITS - LINE_OFF_BITS;

  addr_t                          req_addr;
  logic                           req_rw;
  word_t                          req_wdata;
  logic [TAG_BITS-1:0]            req_tag;
  logic [INDEX_BITS-1:0]          req_index;
  logic [INDEX_BITS-1:0]          rd_index;
  logic [OFFSET_BITS-1:0]         req_offset;

  logic                           store_rd_en;
  logic                           store_line_wr;
  logic                           store_age_wr;
  logic                           fill_load;
  logic                           use_fill;

  logic [WAYS-1:0][TAG_BITS-1:0]  way_tag;
  logic [WAYS-1:0][LINE_BITS-1:0] way_data;
  way_mask_t                      way_valid;
  way_mask_t                      way_dirty;
  age_t [WAYS-1:0]                way_age;

  logic                           hit;
  way_mask_t                      hit_way;
  way_mask_t                      victim_way;
  way_mask_t                      wr_way;
  logic                           victim_dirty;
  logic [TAG_BITS-1:0]            victim_tag;
  age_t [WAYS-1:0]                new_ages;
  logic [LINE_BITS-1:0]           new_data;
  word_t                          rd_word;

  // Address fields of the registered request
  assign req_tag    = req_addr[ADDR_BITS-1 -: TAG_BITS];
  assign req_index  = req_addr[LINE_OFF_BITS +: INDEX_BITS];
  assign req_offset = req_addr[BYTE_BITS +: OFFSET_BITS];

  // The set read starts with the incoming address at the accepting edge
  assign rd_index = cpu_req_addr[LINE_OFF_BITS +: INDEX_BITS];

  assign wr_way = use_fill ? victim_way : hit_way;  // Miss refills the victim

  cache_ctrl #(
    .SETS           (SETS),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_cache_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req_enable (cpu_req_enable),
    .cpu_req_rw     (cpu_req_rw),
    .cpu_req_addr   (cpu_req_addr),
    .cpu_req_wdata  (cpu_req_wdata),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_res_ready  (cpu_res_ready),
    .cpu_res_rdata  (cpu_res_rdata),
    .mem_req_enable (mem_req_enable),
    .mem_req_rw     (mem_req_rw),
    .mem_req_addr   (mem_req_addr),
    .mem_res_ready  (mem_res_ready),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .rd_word        (rd_word),
    .req_addr       (req_addr),
    .req_rw         (req_rw),
    .req_wdata      (req_wdata),
    .store_rd_en    (store_rd_en),
    .store_line_wr  (store_line_wr),
    .store_age_wr   (store_age_wr),
    .fill_load      (fill_load),
    .use_fill       (use_fill)
  );

  line_store #(
    .SETS           (SETS),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_line_store (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (store_rd_en),
    .rd_index  (rd_index),
    .wr_index  (req_index),
    .line_wr   (store_line_wr),
    .age_wr    (store_age_wr),
    .wr_way    (wr_way),
    .wr_tag    (req_tag),
    .wr_data   (new_data),
    .wr_dirty  (req_rw),
    .new_ages  (new_ages),
    .way_tag   (way_tag),
    .way_data  (way_data),
    .way_valid (way_valid),
    .way_dirty (way_dirty),
    .way_age   (way_age)
  );

  way_select #(
    .SETS           (SETS),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_way_select (
    .req_tag      (req_tag),
    .way_tag      (way_tag),
    .way_valid    (way_valid),
    .way_dirty    (way_dirty),
    .way_age      (way_age),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .new_ages     (new_ages)
  );

  line_update #(
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_line_update (
    .clk           (clk),
    .rst_n         (rst_n),
    .fill_load     (fill_load),
    .mem_res_rdata (mem_res_rdata),
    .use_fill      (use_fill),
    .way_data      (way_data),
    .hit_way       (hit_way),
    .victim_way    (victim_way),
    .req_rw        (req_rw),
    .req_offset    (req_offset),
    .req_wdata     (req_wdata),
    .new_data      (new_data),
    .victim_data   (mem_req_wdata),
    .rd_word       (rd_word)
  );

endmodule

`default_nettype wire

// File: hdl/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store #(
  parameter  int SETS           = 16,
  parameter  int WORDS_PER_LINE = 4,
  localparam int INDEX_BITS     = $clog2(SETS),
  localparam int LINE_BITS      = WORDS_PER_LINE * cache_pkg::WORD_BITS,
  localparam int LINE_OFF_BITS  = $clog2(LINE_BITS / 8),
  localparam int TAG_BITS       = cache_pkg::ADDR_BITS - INDEX_BITS - LINE_OFF_BITS
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       rd_en,
  input  logic [INDEX_BITS-1:0]                      rd_index,
  input  logic [INDEX_BITS-1:0]                      wr_index,
  input  logic                                       line_wr,
  input  logic                                       age_wr,
  input  cache_pkg::way_mask_t                       wr_way,
  input  logic [TAG_BITS-1:0]                        wr_tag,
  input  logic [LINE_BITS-1:0]                       wr_data,
  input  logic                                       wr_dirty,
  input  cache_pkg::age_t [cache_pkg::WAYS-1:0]      new_ages,
  output logic [cache_pkg::WAYS-1:0][TAG_BITS-1:0]   way_tag,
  output logic [cache_pkg::WAYS-1:0][LINE_BITS-1:0]  way_data,
  output cache_pkg::way_mask_t                       way_valid,
  output cache_pkg::way_mask_t                       way_dirty,
  output cache_pkg::age_t [cache_pkg::WAYS-1:0]      way_age
);

  import cache_pkg::*;

  way_mask_t             valid_q [SETS];
  age_t [WAYS-1:0]       age_q   [SETS];
  way_mask_t             dirty_q [SETS];
  logic [TAG_BITS-1:0]   tag_q   [SETS][WAYS];
  logic [LINE_BITS-1:0]  data_q  [SETS][WAYS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < WAYS; w++) begin
          age_q[s][w] <= age_t'(w);  // Way i starts at age i
        end
      end
    end else begin
      if (age_wr) begin
        age_q[wr_index] <= new_ages;
      end
      if (line_wr) begin
        valid_q[wr_index] <= valid_q[wr_index] | wr_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_wr) begin
      for (int w = 0; w < WAYS; w++) begin
        if (wr_way[w]) begin
          tag_q[wr_index][w]   <= wr_tag;
          data_q[wr_index][w]  <= wr_data;
          dirty_q[wr_index][w] <= wr_dirty;
        end
      end
    end
  end

  // Whole set is captured, it stays put until the next request
  always_ff @(posedge clk) begin
    if (rd_en) begin
      way_valid <= valid_q[rd_index];
      way_dirty <= dirty_q[rd_index];
      way_age   <= age_q[rd_index];
      for (int w = 0; w < WAYS; w++) begin
        way_tag[w]  <= tag_q[rd_index][w];
        way_data[w] <= data_q[rd_index][w];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/line_update.sv
`timescale 1ns/1ps
`default_nettype none

module line_update #(
  parameter  int WORDS_PER_LINE = 4,
  localparam int OFFSET_BITS    = $clog2(WORDS_PER_LINE),
  localparam int LINE_BITS      = WORDS_PER_LINE * cache_pkg::WORD_BITS
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       fill_load,
  input  logic [LINE_BITS-1:0]                       mem_res_rdata,
  input  logic                                       use_fill,
  input  logic [cache_pkg::WAYS-1:0][LINE_BITS-1:0]  way_data,
  input  cache_pkg::way_mask_t                       hit_way,
  input  cache_pkg::way_mask_t                       victim_way,
  input  logic                                       req_rw,
  input  logic [OFFSET_BITS-1:0]                     req_offset,
  input  cache_pkg::word_t                           req_wdata,
  output logic [LINE_BITS-1:0]                       new_data,
  output logic [LINE_BITS-1:0]                       victim_data,
  output cache_pkg::word_t                           rd_word
);

  import cache_pkg::*;

  logic [LINE_BITS-1:0] fill_line;  // Refill line from memory
  logic [LINE_BITS-1:0] hit_line;
  logic [LINE_BITS-1:0] base_line;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_line <= '0;
    end else if (fill_load) begin
      fill_line <= mem_res_rdata;
    end
  end

  // One-hot way masks pick a line by OR
  always_comb begin
    hit_line    = '0;
    victim_data = '0;
    for (int w = 0; w < WAYS; w++) begin
      if (hit_way[w]) begin
        hit_line = hit_line | way_data[w];
      end
      if (victim_way[w]) begin
        victim_data = victim_data | way_data[w];
      end
    end
  end

  assign base_line = use_fill ? fill_line : hit_line;

  always_comb begin
    new_data = base_line;
    if (req_rw) begin
      new_data[req_offset * WORD_BITS +: WORD_BITS] = req_wdata;  // Merge the CPU word
    end
  end

  assign rd_word = new_data[req_offset * WORD_BITS +: WORD_BITS];

endmodule

`default_nettype wire

// File: hdl/way_select.sv
`timescale 1ns/1ps
`default_nettype none

module way_select #(
  parameter  int SETS           = 16,
  parameter  int WORDS_PER_LINE = 4,
  localparam int INDEX_BITS     = $clog2(SETS),
  localparam int LINE_OFF_BITS  = $clog2(WORDS_PER_LINE * cache_pkg::WORD_BITS / 8),
  localparam int TAG_BITS       = cache_pkg::ADDR_BITS - INDEX_BITS - LINE_OFF_BITS
) (
  input  logic [TAG_BITS-1:0]                      req_tag,
  input  logic [cache_pkg::WAYS-1:0][TAG_BITS-1:0] way_tag,
  input  cache_pkg::way_mask_t                     way_valid,
  input  cache_pkg::way_mask_t                     way_dirty,
  input  cache_pkg::age_t [cache_pkg::WAYS-1:0]    way_age,
  output logic                                     hit,
  output cache_pkg::way_mask_t                     hit_way,
  output cache_pkg::way_mask_t                     victim_way,
  output logic                                     victim_dirty,
  output logic [TAG_BITS-1:0]                      victim_tag,
  output cache_pkg::age_t [cache_pkg::WAYS-1:0]    new_ages
);

  import cache_pkg::*;

  way_mask_t use_way;  // Way this access lands in
  age_t      use_age;
  logic      found;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_way[w] = way_valid[w] && (way_tag[w] == req_tag);
    end
  end

  assign hit = |hit_way;

  // Lowest invalid way first, otherwise the least recent one
  always_comb begin
    victim_way = '0;
    found      = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      if (!found && !way_valid[w]) begin
        victim_way[w] = 1'b1;
        found         = 1'b1;
      end
    end
    for (int w = 0; w < WAYS; w++) begin
      if (!found && way_age[w] == AGE_OLDEST) begin
        victim_way[w] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  assign use_way = hit ? hit_way : victim_way;

  always_comb begin
    victim_tag   = '0;
    victim_dirty = 1'b0;
    use_age      = hit ? age_t'(0) : AGE_OLDEST;  // A miss ages as a hit on the oldest way
    for (int w = 0; w < WAYS; w++) begin
      if (victim_way[w]) begin
        victim_tag   = victim_tag | way_tag[w];
        victim_dirty = victim_dirty | (way_valid[w] & way_dirty[w]);
      end
      if (hit_way[w]) begin
        use_age = use_age | way_age[w];
      end
    end
  end

  // Younger ways than the used one age by one and the used way becomes newest
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      if (use_way[w]) begin
        new_ages[w] = '0;
      end else if (way_age[w] < use_age) begin
        new_ages[w] = way_age[w] + age_t'(1);
      end else begin
        new_ages[w] = way_age[w];
      end
    end
  end

endmodule

`default_nettype wire

// File: test/cache_top_props.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top_props (
  input logic             clk,
  input logic             rst_n,
  input logic             cpu_req_ready,
  input logic             cpu_res_ready,
  input logic             mem_req_enable,
  input logic             mem_req_rw,
  input cache_pkg::addr_t mem_req_addr,
  input logic             mem_res_ready
);

  int unsigned fail_count = 0;  // Read by the testbench at the end

  // Response is a single-cycle pulse
  res_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_res_ready |=> !cpu_res_ready)
    else begin
      fail_count++;
      $error("cpu_res_ready high for two cycles");
    end

  // Request fields hold until memory answers
  mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_enable && !mem_res_ready) |=> ($stable(mem_req_rw) && $stable(mem_req_addr)))
    else begin
      fail_count++;
      $error("memory request changed before mem_res_ready");
    end

  no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_enable |-> !cpu_req_ready)  // No new CPU request during memory traffic
    else begin
      fail_count++;
      $error("cpu_req_ready high while mem_req_enable is high");
    end

endmodule

`default_nettype wire

// File: test/cache_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top_tb;

  import cache_pkg::*;

  localparam int SETS           = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;
  localparam int PERIOD         = 100;
  localparam int RESET_CYCLES   = 10;
  localparam int ACCESS_COUNT   = 64;  // CPU accesses over all tests, rounded up
  localparam int ACCESS_CYCLES  = 16;  // Write-back and refill at the longest memory delay
  localparam int WATCHDOG_NS    = 2 * (RESET_CYCLES + ACCESS_COUNT * ACCESS_CYCLES) * PERIOD;

  logic                 clk            = 1'b0;
  logic                 rst_n          = 1'b0;
  logic                 cpu_req_enable = 1'b0;
  logic                 cpu_req_rw     = 1'b0;
  addr_t                cpu_req_addr   = '0;
  word_t                cpu_req_wdata  = '0;
  logic                 cpu_req_ready;
  logic                 cpu_res_ready;
  word_t                cpu_res_rdata;
  logic                 mem_req_enable;
  logic                 mem_req_rw;
  addr_t                mem_req_addr;
  logic [LINE_BITS-1:0] mem_req_wdata;
  logic                 mem_res_ready  = 1'b0;
  logic [LINE_BITS-1:0] mem_res_rdata  = '0;

  logic [LINE_BITS-1:0] mem_lines [addr_t];  // Memory model by line address
  word_t                shadow [addr_t];     // Expected contents by word address
  addr_t                wb_addrs [$];        // Write-back log
  logic [LINE_BITS-1:0] wb_lines [$];
  int                   mem_reads    = 0;
  addr_t                last_rd_addr = '0;
  logic [31:0]          mem_rng      = 32'd33805;
  logic [31:0]          stim_rng     = 32'd33805;
  int                   errors       = 0;
  int                   checks       = 0;
  int                   tests        = 0;
  word_t                rdata;
  int                   cycles;

  always #(PERIOD / 2) clk = ~clk;

  cache_top #(
    .SETS           (SETS),
    .WORDS_PER_LINE (WORDS_PER_LINE)
  ) u_cache_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req_enable (cpu_req_enable),
    .cpu_req_rw     (cpu_req_rw),
    .cpu_req_addr   (cpu_req_addr),
    .cpu_req_wdata  (cpu_req_wdata),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_res_ready  (cpu_res_ready),
    .cpu_res_rdata  (cpu_res_rdata),
    .mem_req_enable (mem_req_enable),
    .mem_req_rw     (mem_req_rw),
    .mem_req_addr   (mem_req_addr),
    .mem_req_wdata  (mem_req_wdata),
    .mem_res_ready  (mem_res_ready),
    .mem_res_rdata  (mem_res_rdata)
  );

  bind cache_ctrl cache_top_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_res_ready  (cpu_res_ready),
    .mem_req_enable (mem_req_enable),
    .mem_req_rw     (mem_req_rw),
    .mem_req_addr   (mem_req_addr),
    .mem_res_ready  (mem_res_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Untouched memory holds its own byte address, upper half inverted
  function automatic word_t initial_word(input addr_t a);
    return {~a[31:16], a[15:0]};
  endfunction

  function automatic logic [LINE_BITS-1:0] initial_line(input addr_t line_addr);
    logic [LINE_BITS-1:0] l;
    for (int j = 0; j < WORDS_PER_LINE; j++) begin
      l[j*WORD_BITS +: WORD_BITS] = initial_word(line_addr + addr_t'(4 * j));
    end
    return l;
  endfunction

  function automatic word_t expected_word(input addr_t a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return initial_word(a);
  endfunction

  function automatic addr_t make_addr(input int tag, input int index, input int word);
    return addr_t'((tag << 8) | (index << 4) | (word << 2));
  endfunction

  // Memory model, answers 1 to 4 cycles after it sees a request
  initial begin : memory_model
    int    delay;
    addr_t a;
    forever begin
      @(negedge clk);
      if (mem_req_enable) begin
        mem_rng = xorshift(mem_rng);
        delay   = 1 + int'(mem_rng % 32'd4);
        repeat (delay - 1) @(negedge clk);
        a = mem_req_addr;
        if (mem_req_rw) begin
          mem_lines[a] = mem_req_wdata;
          wb_addrs.push_back(a);
          wb_lines.push_back(mem_req_wdata);
        end else begin
          mem_reads++;
          last_rd_addr = a;
        end
        @(posedge clk);
        mem_res_ready <= 1'b1;
        mem_res_rdata <= mem_lines.exists(a) ? mem_lines[a] : initial_line(a);
        @(posedge clk);
        mem_res_ready <= 1'b0;
      end
    end
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns %s: got address %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("FAIL %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // One CPU access, returns rdata and the cycles from acceptance to response
  task automatic cpu_access(input logic rw, input addr_t a, input word_t wdata);
    @(posedge clk);
    cpu_req_enable <= 1'b1;
    cpu_req_rw     <= rw;
    cpu_req_addr   <= a;
    cpu_req_wdata  <= wdata;
    @(negedge clk);
    while (!cpu_req_ready) @(negedge clk);
    @(posedge clk);  // Accepting edge
    cpu_req_enable <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!cpu_res_ready);
    rdata = cpu_res_rdata;
    if (rw) begin
      shadow[a] = wdata;
    end
  endtask

  task automatic read_check(input string what, input addr_t a);
    cpu_access(1'b0, a, '0);
    check_word(what, rdata, expected_word(a));
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s passed", name);
    end else begin
      $display("test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_flag("cpu_req_ready after reset", cpu_req_ready, 1'b1);
    check_flag("mem_req_enable after reset", mem_req_enable, 1'b0);
    check_flag("cpu_res_ready after reset", cpu_res_ready, 1'b0);
    report_test("reset", e0);
  endtask

  task automatic test_read_miss();
    int e0;
    int r0;
    e0 = errors;
    r0 = mem_reads;
    read_check("read miss word", 32'h0000_1004);
    check_count("memory reads on read miss", mem_reads - r0, 1);
    check_addr("refill address", last_rd_addr, 32'h0000_1000);
    r0 = mem_reads;
    read_check("read hit word", 32'h0000_100C);
    check_count("read hit cycles", cycles, 2);
    check_count("memory reads on read hit", mem_reads - r0, 0);
    report_test("read_miss", e0);
  endtask

  task automatic test_write();
    int e0;
    int r0;
    int w0;
    e0 = errors;
    r0 = mem_reads;
    w0 = wb_addrs.size();
    cpu_access(1'b1, 32'h0000_1008, 32'hA5A5_0001);  // Line is cached already
    read_check("read after write hit", 32'h0000_1008);
    check_count("memory requests on write hit", mem_reads - r0 + wb_addrs.size() - w0, 0);
    r0 = mem_reads;
    cpu_access(1'b1, 32'h0000_2014, 32'h5A5A_0002);
    check_count("memory reads on write miss", mem_reads - r0, 1);
    check_addr("write miss refill address", last_rd_addr, 32'h0000_2010);
    read_check("written word after write miss", 32'h0000_2014);
    read_check("word 0 after write miss", 32'h0000_2010);
    read_check("word 3 after write miss", 32'h0000_201C);
    report_test("write", e0);
  endtask

  task automatic test_writeback();
    int                   e0;
    int                   r0;
    int                   w0;
    logic [LINE_BITS-1:0] exp_line;
    logic [LINE_BITS-1:0] got_line;
    e0 = errors;
    w0 = wb_addrs.size();
    cpu_access(1'b1, make_addr('h40, 3, 2), 32'hC0DE_0040);
    for (int t = 1; t < 4; t++) begin
      read_check($sformatf("read of tag %0h", 'h40 + t), make_addr('h40 + t, 3, 0));
    end
    r0 = mem_reads;
    read_check("fifth tag read", make_addr('h44, 3, 1));
    check_count("write-backs on fifth tag", wb_addrs.size() - w0, 1);
    check_count("memory reads on fifth tag", mem_reads - r0, 1);
    if (wb_addrs.size() > w0) begin
      check_addr("write-back address", wb_addrs[w0], make_addr('h40, 3, 0));
      exp_line = initial_line(make_addr('h40, 3, 0));
      exp_line[2*WORD_BITS +: WORD_BITS] = 32'hC0DE_0040;  // Word written before eviction
      got_line = wb_lines[w0];
      for (int j = 0; j < WORDS_PER_LINE; j++) begin
        check_word($sformatf("write-back word %0d", j), got_line[j*WORD_BITS +: WORD_BITS],
                   exp_line[j*WORD_BITS +: WORD_BITS]);
      end
    end
    report_test("writeback", e0);
  endtask

  task automatic test_lru();
    int e0;
    int r0;
    int w0;
    e0 = errors;
    w0 = wb_addrs.size();
    for (int t = 0; t < 4; t++) begin
      read_check($sformatf("fill of tag %0h", 'h50 + t), make_addr('h50 + t, 5, 0));
    end
    r0 = mem_reads;
    read_check("re-read of first tag", make_addr('h50, 5, 1));
    check_count("memory reads on re-read", mem_reads - r0, 0);
    read_check("fifth tag read", make_addr('h54, 5, 0));
    r0 = mem_reads;
    read_check("first tag after eviction", make_addr('h50, 5, 2));
    check_count("memory reads for first tag", mem_reads - r0, 0);
    r0 = mem_reads;
    read_check("second tag after eviction", make_addr('h51, 5, 2));
    check_count("memory reads for second tag", mem_reads - r0, 1);
    check_count("write-backs of clean lines", wb_addrs.size() - w0, 0);
    report_test("lru", e0);
  endtask

  // Two sets, six tags, mixed reads and writes
  task automatic test_random();
    int          e0;
    logic [31:0] r;
    addr_t       a;
    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      stim_rng = xorshift(stim_rng);
      r        = stim_rng;
      a        = make_addr('h60 + int'(r[7:0] % 8'd6), 8 + int'(r[8]), int'(r[10:9]));
      if (r[11]) begin
        stim_rng = xorshift(stim_rng);
        cpu_access(1'b1, a, stim_rng);
      end else begin
        read_check($sformatf("random read %0d at %h", i, a), a);
      end
    end
    report_test("random", e0);
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: tests did not end within %0d ns", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

  initial begin : main
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_read_miss();
    test_write();
    test_writeback();
    test_lru();
    test_random();
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
             errors, u_cache_top.u_cache_ctrl.u_props.fail_count);
    if (errors == 0 && u_cache_top.u_cache_ctrl.u_props.fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
